//--- design/spi_regs_pkg.sv
// spi_regs_pkg
// shared widths and types for the spi register slave
// command byte layout and arbiter port numbering

package spi_regs_pkg;

	localparam int addr_w = 7;	// 128 registers
	localparam int data_w = 8;	// register and spi word

	typedef logic [addr_w-1:0] reg_addr_t;
	typedef logic [data_w-1:0] reg_data_t;

	typedef struct packed {
		logic      wr;	// 1 = write frame
		reg_addr_t addr;	// start address
	} cmd_fields_t;

	// first byte of a frame is a command, every later one is plain data
	typedef union packed {
		cmd_fields_t cmd;
		reg_data_t   raw;
	} spi_byte_u;

	localparam bit arb_spi  = 1'b0;	// arbiter port of the spi frame ctrl
	localparam bit arb_host = 1'b1;	// arbiter port of the host port

endpackage

//--- design/reg_bus_if.sv
// reg_bus_if
// register bus between requesters, arbiter and store
// req level held until a one-cycle gnt, rdata valid with gnt
`timescale 1ns/1ps

interface reg_bus_if;
	import spi_regs_pkg::*;

	logic      req;	// held until gnt
	logic      we;	// 1 = write
	reg_addr_t addr;
	reg_data_t wdata;
	logic      gnt;	// one-cycle pulse
	reg_data_t rdata;	// valid in gnt cycle

	modport requester (
		output req, we, addr, wdata,
		input  gnt, rdata
	);

	modport target (
		input  req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

//--- design/spi_slave.sv
// spi_slave
// spi byte engine, oversamples cs/sclk/mosi on sys_clk
// shifts mosi in and miso out per CPOL/CPHA, one rx_valid per byte
`timescale 1ns/1ps

module spi_slave #(
	parameter bit CPOL = 1'b1,	// sclk idle level
	parameter bit CPHA = 1'b1	// 0: sample first edge, 1: sample second edge
) (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    cs,
	input  logic                    sclk,
	input  logic                    mosi,
	output logic                    miso,
	output logic                    frame_start,	// synced cs fall
	output spi_regs_pkg::reg_data_t rx_byte,
	output logic                    rx_valid,
	input  spi_regs_pkg::reg_data_t tx_byte,
	input  logic                    tx_load	// copy tx_byte into miso shifter
);
	import spi_regs_pkg::*;

	localparam logic [1:0] s_idle = 2'd0;	// cs high
	localparam logic [1:0] s_byte = 2'd1;	// counting sclk edges
	localparam logic [1:0] s_ack  = 2'd2;	// byte complete

	logic [2:0] cs_sync;	// [1] synced, [2] one cycle older
	logic [2:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [1:0] state;
	logic [3:0] edge_cnt;	// 16 edges per byte
	reg_data_t  rx_shift;
	reg_data_t  tx_shift;
	logic       sclk_rise;
	logic       sclk_fall;
	logic       lead_edge;
	logic       trail_edge;
	logic       bit_edge;
	logic       do_sample;
	logic       do_shift;
	logic       byte_end;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_sync   <= 3'b111;	// idle, no frame
			sclk_sync <= {3{CPOL}};
			mosi_sync <= 2'b00;
		end else begin
			cs_sync   <= {cs_sync[1:0], cs};
			sclk_sync <= {sclk_sync[1:0], sclk};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	assign frame_start = cs_sync[2] & ~cs_sync[1];
	assign sclk_rise   = sclk_sync[1] & ~sclk_sync[2];
	assign sclk_fall   = ~sclk_sync[1] & sclk_sync[2];
	assign lead_edge   = CPOL ? sclk_fall : sclk_rise;	// leaves idle level
	assign trail_edge  = CPOL ? sclk_rise : sclk_fall;	// returns to idle

	// even count waits for the leading edge, odd for the trailing one
	assign bit_edge  = (state == s_byte) && (edge_cnt[0] ? trail_edge : lead_edge);
	assign do_sample = bit_edge && (edge_cnt[0] == CPHA);
	assign do_shift  = bit_edge && (edge_cnt[0] != CPHA) && !(CPHA && edge_cnt == 4'd0);	// msb already out
	assign byte_end  = bit_edge && (edge_cnt == 4'd15);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state    <= s_idle;
			edge_cnt <= 4'd0;
		end else if (cs_sync[1]) begin	// cs high drops a partial byte
			state    <= s_idle;
			edge_cnt <= 4'd0;
		end else begin
			case (state)
				s_idle: begin
					state    <= s_byte;
					edge_cnt <= 4'd0;
				end
				s_byte: if (bit_edge) begin
					edge_cnt <= edge_cnt + 4'd1;	// wraps to 0 after 15
					if (byte_end)
						state <= s_ack;
				end
				s_ack: state <= s_byte;
				default: state <= s_idle;
			endcase
		end
	end

	assign rx_valid = (state == s_ack);	// cycle after 16th edge
	assign rx_byte  = rx_shift;

	always_ff @(posedge sys_clk) begin
		if (do_sample)
			rx_shift <= {rx_shift[data_w-2:0], mosi_sync[1]};	// msb first
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			tx_shift <= '0;
		else if (tx_load)
			tx_shift <= tx_byte;
		else if (cs_sync[1] || byte_end)	// unloaded byte sends 0x00
			tx_shift <= '0;
		else if (do_shift)
			tx_shift <= {tx_shift[data_w-2:0], 1'b0};
	end

	assign miso = tx_shift[data_w-1] & ~cs;	// low whenever the pin is deselected

endmodule

//--- design/spi_frame_ctrl.sv
// spi_frame_ctrl
// turns received spi bytes into register bus accesses
// byte 0 is the command, later bytes are data at consecutive addresses
`timescale 1ns/1ps

module spi_frame_ctrl (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    frame_start,
	input  spi_regs_pkg::reg_data_t rx_byte,
	input  logic                    rx_valid,
	output spi_regs_pkg::reg_data_t tx_byte,
	output logic                    tx_load,
	reg_bus_if.requester            bus
);
	import spi_regs_pkg::*;

	spi_byte_u rx_u;	// cmd or raw view of the same byte
	logic      cmd_phase;	// next byte is the command
	logic      wr_frame;
	reg_addr_t ptr;	// next register of the frame
	logic      issue;

	assign rx_u = rx_byte;

	// read frames fetch after the command and after each data byte
	assign issue = rx_valid && !bus.req && (!cmd_phase || !rx_u.cmd.wr);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cmd_phase <= 1'b1;
			wr_frame  <= 1'b0;
			ptr       <= '0;
			bus.req   <= 1'b0;
			tx_load   <= 1'b0;
		end else begin
			tx_load <= bus.gnt && !bus.we;	// read data to miso shifter

			if (issue)
				bus.req <= 1'b1;
			else if (bus.gnt)
				bus.req <= 1'b0;

			if (frame_start)
				cmd_phase <= 1'b1;
			else if (rx_valid)
				cmd_phase <= 1'b0;

			if (rx_valid && cmd_phase)
				wr_frame <= rx_u.cmd.wr;

			if (rx_valid && cmd_phase)
				ptr <= rx_u.cmd.addr;
			else if (rx_valid && wr_frame && !bus.req)
				ptr <= ptr + 1'b1;	// wraps 127 -> 0
			else if (bus.gnt && !bus.we)
				ptr <= ptr + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (issue) begin
			bus.we    <= cmd_phase ? 1'b0 : wr_frame;
			bus.addr  <= cmd_phase ? rx_u.cmd.addr : ptr;
			bus.wdata <= rx_u.raw;
		end
		if (bus.gnt)
			tx_byte <= bus.rdata;
	end

endmodule

//--- design/host_port.sv
// host_port
// parallel host access, one strobe becomes one register bus access
// host_done pulses once the access is granted
`timescale 1ns/1ps

module host_port (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    host_req,	// one-cycle strobe
	input  logic                    host_we,
	input  spi_regs_pkg::reg_addr_t host_addr,
	input  spi_regs_pkg::reg_data_t host_wdata,
	output spi_regs_pkg::reg_data_t host_rdata,	// held until next access
	output logic                    host_done,
	reg_bus_if.requester            bus
);
	logic accept;

	assign accept = host_req && !bus.req;	// strobe while busy is dropped

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			bus.req    <= 1'b0;
			host_done  <= 1'b0;
			host_rdata <= '0;
		end else begin
			host_done <= bus.gnt;
			if (accept)
				bus.req <= 1'b1;
			else if (bus.gnt)
				bus.req <= 1'b0;
			if (bus.gnt)
				host_rdata <= bus.rdata;	// write returns the stored value
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			bus.we    <= host_we;
			bus.addr  <= host_addr;
			bus.wdata <= host_wdata;
		end
	end

endmodule

//--- design/reg_arbiter.sv
// reg_arbiter
// round-robin arbiter between the spi and host requesters
// samples requests, forwards the winner a cycle later, routes gnt back
`timescale 1ns/1ps

module reg_arbiter (
	input  logic         sys_clk,
	input  logic         sys_rst_n,
	reg_bus_if.target    spi_bus,
	reg_bus_if.target    host_bus,
	reg_bus_if.requester mem_bus
);
	import spi_regs_pkg::*;

	logic last_srv;	// port served last, also owner of the open access
	logic win;
	logic any_req;

	assign any_req = spi_bus.req || host_bus.req;

	always_comb begin
		if (spi_bus.req && host_bus.req)
			win = ~last_srv;	// tie goes to the other port
		else if (host_bus.req)
			win = arb_host;
		else
			win = arb_spi;
	end

	// mem_bus.req doubles as busy, so no new pick in the gnt cycle
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			mem_bus.req <= 1'b0;
			last_srv    <= arb_host;	// spi wins the first tie
		end else if (!mem_bus.req && any_req) begin
			mem_bus.req <= 1'b1;
			last_srv    <= win;
		end else if (mem_bus.gnt) begin
			mem_bus.req <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!mem_bus.req) begin
			mem_bus.we    <= (win == arb_host) ? host_bus.we : spi_bus.we;
			mem_bus.addr  <= (win == arb_host) ? host_bus.addr : spi_bus.addr;
			mem_bus.wdata <= (win == arb_host) ? host_bus.wdata : spi_bus.wdata;
		end
	end

	assign spi_bus.gnt    = mem_bus.gnt && (last_srv == arb_spi);
	assign host_bus.gnt   = mem_bus.gnt && (last_srv == arb_host);
	assign spi_bus.rdata  = (last_srv == arb_spi) ? mem_bus.rdata : '0;
	assign host_bus.rdata = (last_srv == arb_host) ? mem_bus.rdata : '0;

endmodule

//--- design/reg_mem.sv
// reg_mem
// 128 x 8 register store, cleared by reset
// gnt one cycle after req, rdata is old value on read, new on write
`timescale 1ns/1ps

module reg_mem (
	input  logic      sys_clk,
	input  logic      sys_rst_n,
	reg_bus_if.target bus
);
	import spi_regs_pkg::*;

	localparam int depth = 1 << addr_w;

	reg_data_t regs [depth];
	logic      take;

	assign take = bus.req && !bus.gnt;	// req still high in gnt cycle

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			bus.gnt <= 1'b0;
			for (int i = 0; i < depth; i++)
				regs[i] <= '0;
		end else begin
			bus.gnt <= take;
			if (take && bus.we)
				regs[bus.addr] <= bus.wdata;	// lands on the gnt edge
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take)
			bus.rdata <= bus.we ? bus.wdata : regs[bus.addr];
	end

endmodule

//--- design/spi_regs_top.sv
// spi_regs_top
// spi register slave, spi master and parallel host share 128 registers
`timescale 1ns/1ps

module spi_regs_top #(
	parameter bit CPOL = 1'b1,
	parameter bit CPHA = 1'b1
) (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    cs,
	input  logic                    sclk,
	input  logic                    mosi,
	output logic                    miso,
	input  logic                    host_req,
	input  logic                    host_we,
	input  spi_regs_pkg::reg_addr_t host_addr,
	input  spi_regs_pkg::reg_data_t host_wdata,
	output spi_regs_pkg::reg_data_t host_rdata,
	output logic                    host_done
);
	import spi_regs_pkg::*;

	logic      frame_start;
	reg_data_t rx_byte;
	logic      rx_valid;
	reg_data_t tx_byte;
	logic      tx_load;

	reg_bus_if spi_bus ();	// frame ctrl -> arbiter
	reg_bus_if host_bus ();	// host port -> arbiter
	reg_bus_if mem_bus ();	// arbiter -> store

	spi_slave #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) spi_slave_i (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.cs          (cs),
		.sclk        (sclk),
		.mosi        (mosi),
		.miso        (miso),
		.frame_start (frame_start),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.tx_byte     (tx_byte),
		.tx_load     (tx_load)
	);

	spi_frame_ctrl spi_frame_ctrl_i (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.frame_start (frame_start),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.tx_byte     (tx_byte),
		.tx_load     (tx_load),
		.bus         (spi_bus.requester)
	);

	host_port host_port_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.host_done  (host_done),
		.bus        (host_bus.requester)
	);

	reg_arbiter reg_arbiter_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.spi_bus   (spi_bus.target),
		.host_bus  (host_bus.target),
		.mem_bus   (mem_bus.requester)
	);

	reg_mem reg_mem_i (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.bus       (mem_bus.target)
	);

endmodule

//--- bench/spi_regs_chk.sv
// spi_regs_chk
// bus and pin protocol checks, bound into spi_regs_top
`timescale 1ns/1ps

module spi_regs_chk (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic cs,
	input logic miso,
	input logic host_req,
	input logic host_done,
	input logic spi_req,
	input logic spi_gnt,
	input logic host_bus_req,
	input logic host_gnt
);
	logic req_seen;	// host strobe since the last done

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			req_seen <= 1'b0;
		else if (host_req)
			req_seen <= 1'b1;
		else if (host_done)
			req_seen <= 1'b0;
	end

	a_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		host_done |=> !host_done) else $error("host_done held longer than one cycle");
	a_done_after_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		host_done |-> req_seen) else $error("host_done without a host_req");
	a_miso_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		cs |-> !miso) else $error("miso high while cs is high");
	a_one_gnt: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(spi_gnt && host_gnt)) else $error("spi and host granted together");
	a_spi_gnt_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		spi_gnt |-> spi_req) else $error("spi gnt without spi req");
	a_host_gnt_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		host_gnt |-> host_bus_req) else $error("host gnt without host req");

endmodule

bind spi_regs_top spi_regs_chk chk_i (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.cs           (cs),
	.miso         (miso),
	.host_req     (host_req),
	.host_done    (host_done),
	.spi_req      (spi_bus.req),
	.spi_gnt      (spi_bus.gnt),
	.host_bus_req (host_bus.req),
	.host_gnt     (host_bus.gnt)
);

//--- bench/spi_regs_tb.sv
// spi_regs_tb
// testbench for the spi register slave, mode 3 spi master and host driver
// read data is compared against a 128 byte reference array
`timescale 1ns/1ps

module spi_regs_tb;
	import spi_regs_pkg::*;

	localparam int half         = 6;	// sclk half period in sys_clk
	localparam int gap          = 10;	// cs setup and inter-byte gap
	localparam int host_timeout = 20;	// cycles from strobe to done, at most
	localparam int burst_pairs  = 100;	// cap on host write/read pairs in test 5
	localparam int spi_bytes    = 24;
	localparam int host_ops     = 52 + 2 * burst_pairs;
	localparam int watchdog_cycles = 2 * (spi_bytes * (16 * half + gap) + 20 * host_ops);

	logic      sys_clk;
	logic      sys_rst_n;
	logic      cs;
	logic      sclk;
	logic      mosi;
	logic      miso;
	logic      host_req;
	logic      host_we;
	reg_addr_t host_addr;
	reg_data_t host_wdata;
	reg_data_t host_rdata;
	logic      host_done;
	reg_data_t ref_regs [128];	// expected register contents
	reg_data_t frame_buf [$];	// bytes sent in the next frame, command first
	reg_data_t rx_buf [$];	// bytes seen on miso
	int        err_cnt;
	int        check_cnt;
	int        test_errs;
	int        test_checks;
	bit        burst_done;

	spi_regs_top dut_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.cs         (cs),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso),
		.host_req   (host_req),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.host_done  (host_done)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;	// 40 ns period
	end

	initial begin
		repeat (watchdog_cycles) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("sim failed");
		$finish;
	end

	task automatic check_value(input string what, input reg_data_t got, input reg_data_t exp);
		check_cnt++;
		assert (got === exp) else begin
			$display("ERROR %0t: %s returned 0x%02h, expected 0x%02h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	task automatic start_test();
		test_errs   = err_cnt;
		test_checks = check_cnt;
	endtask

	task automatic finish_test(input int num, input string name);
		$display("test %0d %s: %0d checks, %0d errors", num, name,
			check_cnt - test_checks, err_cnt - test_errs);
	endtask

	// one strobe, then wait for done with a bound
	task automatic host_access(input logic we, input reg_addr_t addr, input reg_data_t wdata,
		output reg_data_t rdata);
		int wait_cnt;
		wait_cnt = 0;
		@(posedge sys_clk);
		host_req   <= 1'b1;
		host_we    <= we;
		host_addr  <= addr;
		host_wdata <= wdata;
		@(posedge sys_clk);
		host_req <= 1'b0;
		@(negedge sys_clk);
		while (!host_done && wait_cnt < host_timeout) begin
			@(negedge sys_clk);
			wait_cnt++;
		end
		if (!host_done) begin
			$display("host access to address %0d got no done in %0d cycles", addr, host_timeout);
			err_cnt++;
		end
		rdata = host_rdata;	// held after done
	endtask

	task automatic host_write(input reg_addr_t addr, input reg_data_t data);
		reg_data_t unused;
		host_access(1'b1, addr, data, unused);
		ref_regs[addr] = data;
	endtask

	task automatic host_check(input reg_addr_t addr);
		reg_data_t got;
		host_access(1'b0, addr, '0, got);
		check_value($sformatf("host read at %0d", addr), got, ref_regs[addr]);
	endtask

	// mode 3: idle high, change on fall, sample on rise, msb first
	task automatic spi_byte(input reg_data_t tx, input int nbits, output reg_data_t rx);
		reg_data_t sh;
		sh = tx;
		rx = '0;
		repeat (nbits) begin
			@(posedge sys_clk);
			sclk <= 1'b0;
			mosi <= sh[data_w-1];
			sh = sh << 1;
			repeat (half - 1) @(posedge sys_clk);
			@(negedge sys_clk);
			rx = {rx[data_w-2:0], miso};	// settled well before the rise
			@(posedge sys_clk);
			sclk <= 1'b1;
			repeat (half - 1) @(posedge sys_clk);
		end
	endtask

	// whole frame from frame_buf, last byte may be cut to last_bits
	task automatic spi_frame(input int last_bits);
		reg_data_t rx;
		rx_buf = {};
		@(posedge sys_clk);
		cs <= 1'b0;
		repeat (gap) @(posedge sys_clk);
		for (int b = 0; b < frame_buf.size(); b++) begin
			spi_byte(frame_buf[b], (b == frame_buf.size() - 1) ? last_bits : data_w, rx);
			rx_buf.push_back(rx);
			repeat (gap) @(posedge sys_clk);
		end
		cs <= 1'b1;	// also drops a cut byte
		repeat (gap) @(posedge sys_clk);
	endtask

	task automatic spi_write(input reg_addr_t start, input int n);
		frame_buf = {};
		frame_buf.push_back({1'b1, start});
		repeat (n) frame_buf.push_back(reg_data_t'($urandom));
		spi_frame(data_w);
		for (int i = 1; i <= n; i++)
			ref_regs[reg_addr_t'(start + i - 1)] = frame_buf[i];	// wraps at 127
	endtask

	initial begin
		reg_addr_t a;
		reg_addr_t addr_q [$];
		void'($urandom(65));
		err_cnt    = 0;
		check_cnt  = 0;
		burst_done = 1'b0;
		ref_regs   = '{default: '0};
		sys_rst_n  = 1'b0;
		cs         = 1'b1;
		sclk       = 1'b1;	// CPOL 1 idle level
		mosi       = 1'b0;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		repeat (3) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		start_test();
		@(negedge sys_clk);
		check_value("miso after reset", {7'b0, miso}, '0);
		check_value("host_done after reset", {7'b0, host_done}, '0);
		repeat (8) host_check(reg_addr_t'($urandom));
		finish_test(1, "reset values");

		start_test();
		repeat (8) begin
			addr_q.push_back(reg_addr_t'($urandom));
			host_write(addr_q[addr_q.size() - 1], reg_data_t'($urandom));
		end
		for (int i = 0; i < addr_q.size(); i++)
			host_check(addr_q[i]);
		finish_test(2, "host write and read");

		start_test();
		a = reg_addr_t'($urandom);
		spi_write(a, 4);
		for (int i = 0; i < 4; i++)
			host_check(reg_addr_t'(a + i));
		spi_write(7'd126, 4);	// 126, 127, 0, 1
		for (int i = 0; i < 4; i++)
			host_check(reg_addr_t'(126 + i));
		finish_test(3, "spi write frames");

		start_test();
		a = reg_addr_t'($urandom);
		for (int i = 0; i < 3; i++)
			host_write(reg_addr_t'(a + i), reg_data_t'($urandom));
		frame_buf = {};
		frame_buf.push_back({1'b0, a});
		repeat (3) frame_buf.push_back(reg_data_t'($urandom));	// dummy bytes
		spi_frame(data_w);
		check_value("miso during command byte", rx_buf[0], '0);
		for (int i = 0; i < 3; i++)
			check_value($sformatf("spi read at %0d", reg_addr_t'(a + i)), rx_buf[i + 1],
				ref_regs[reg_addr_t'(a + i)]);
		finish_test(4, "spi read frame");

		start_test();
		a = reg_addr_t'($urandom);
		fork
			begin
				spi_write(a, 6);
				burst_done = 1'b1;
			end
			for (int k = 0; k < burst_pairs && !burst_done; k++) begin	// other half of the map
				host_write(reg_addr_t'(a + 64 + k % 8), reg_data_t'($urandom));
				host_check(reg_addr_t'(a + 64 + k % 8));
			end
		join
		for (int i = 0; i < 6; i++)
			host_check(reg_addr_t'(a + i));
		for (int i = 0; i < 8; i++)
			host_check(reg_addr_t'(a + 64 + i));
		finish_test(5, "host traffic during spi burst");

		start_test();
		a = reg_addr_t'($urandom);
		host_write(reg_addr_t'(a + 1), reg_data_t'($urandom));
		frame_buf = {};
		frame_buf.push_back({1'b1, a});
		frame_buf.push_back(reg_data_t'($urandom));
		frame_buf.push_back(reg_data_t'($urandom));
		spi_frame(4);	// second data byte cut after 4 bits
		ref_regs[a] = frame_buf[1];
		host_check(a);
		host_check(reg_addr_t'(a + 1));
		finish_test(6, "frame cut by cs");

		$display("6 tests, %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- spi_regs.f
design/spi_regs_pkg.sv
design/reg_bus_if.sv
design/spi_slave.sv
design/spi_frame_ctrl.sv
design/host_port.sv
design/reg_arbiter.sv
design/reg_mem.sv
design/spi_regs_top.sv
bench/spi_regs_chk.sv
bench/spi_regs_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the spi register slave testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f spi_regs.f --top-module spi_regs_tb \
	-Mdir obj_dir -o spi_regs_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/spi_regs_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^sim passed$" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
